// ==== logic/oppm_pkg.sv ====
package oppm_pkg;

  // Modulation and framing
  localparam int N_MOD       = 2;                          // Bits per symbol
  localparam int SLOT_CT     = 2**N_MOD;                   // Slots per symbol
  localparam int L           = 16;                         // Ticks per slot
  localparam int SYM_LEN     = SLOT_CT * L;                // Cycles per symbol
  localparam int DELTA       = 3;                          // In-slot half window
  localparam int N_PKT       = 8;                          // Packet bits
  localparam int DATA_SYM_CT = (N_PKT + N_MOD - 1) / N_MOD; // Rounded up
  localparam int PRE_CT      = 2;                          // Preamble symbols
  localparam int FILTER_LEN  = 3;                          // Glitch filter depth

  // Derived widths
  localparam int L_SZ    = $clog2(L);
  localparam int PRE_SZ  = $clog2(PRE_CT + 1);
  localparam int DSYM_SZ = $clog2(DATA_SYM_CT + 1);

  typedef logic [N_MOD-1:0] sym_t;
  typedef logic [N_PKT-1:0] pkt_t;
  typedef logic [L_SZ-1:0]  tick_t;

  // Tick and count landmarks
  localparam tick_t              LAST_TICK     = tick_t'(L - 1);
  localparam tick_t              DELTA_TICK    = tick_t'(DELTA);
  localparam tick_t              NEAR_END_TICK = tick_t'(L - DELTA);     // Counts as next slot
  localparam tick_t              CHECK_TICK    = tick_t'(L - 1 - DELTA); // Missing-pulse check
  localparam sym_t               LAST_SLOT     = sym_t'(SLOT_CT - 1);
  localparam logic [PRE_SZ-1:0]  PRE_DONE      = PRE_SZ'(PRE_CT);
  localparam logic [DSYM_SZ-1:0] LAST_DSYM     = DSYM_SZ'(DATA_SYM_CT - 1);

  typedef enum logic [1:0] {WAIT, PREAM, DATA, ERR} fsm_state_t;

  typedef struct packed {
    logic final_tick;      // Tick counter about to wrap
    logic final_slot;      // Last slot of the symbol
    logic near_begin;      // Within DELTA of a slot start
    sym_t near_slot;       // Slot an edge here belongs to
    logic final_near_tick; // Last tick outside the next window
    logic final_near_slot; // Near slot is the last one
  } slot_pos_t;

  typedef struct packed {
    logic reload;   // Clear the packet register
    logic shift;    // Shift sym in
    sym_t sym;      // Decoded symbol
    logic ready;    // Packet complete
    logic fault;    // Frame error
    logic incoming; // First edge of a new frame
  } buf_ctrl_t;

endpackage

// ==== logic/pulse_qualifier.sv ====
`timescale 1ns/1ns

module pulse_qualifier import oppm_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic pulse,     // Raw pulse line
  output logic pulse_edge // One-cycle strobe on a qualified rise
);

  logic [FILTER_LEN-1:0] history;  // Earlier samples, newest in bit 0
  logic                  filtered;
  logic                  filtered_q;

  always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
      history <= '0;
    end else begin
      history <= {history[FILTER_LEN-2:0], pulse};
    end
  end

  // Pass only once the line has been high long enough
  assign filtered = (&history) & pulse;

  always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
      filtered_q <= 1'b0;
    end else begin
      filtered_q <= filtered;
    end
  end

  // Rising edge of the filtered level; the line must drop before the next one
  assign pulse_edge = filtered & ~filtered_q;

endmodule

// ==== logic/slot_timer.sv ====
`timescale 1ns/1ns

module slot_timer import oppm_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start, // First edge of a frame
  input  logic      clear, // Hold counters at zero
  output slot_pos_t pos
);

  logic  run_q;
  logic  run;
  tick_t tick;
  sym_t  slot;
  sym_t  next_slot;
  logic  at_begin;
  logic  at_end;

  // Start counts as tick 0 in its own cycle
  assign run = run_q | start;

  always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
      run_q <= 1'b0;
    end else begin
      run_q <= run & ~clear; // Latch start until cleared
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
      tick <= '0;
    end else if (~run | clear | pos.final_tick) begin
      tick <= '0;
    end else begin
      tick <= tick + 1'b1;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
      slot <= '0;
    end else if (~run | clear) begin
      slot <= '0;
    end else if (pos.final_tick) begin
      slot <= pos.final_slot ? '0 : slot + 1'b1;
    end
  end

  always_comb begin
    at_begin  = tick <= DELTA_TICK;
    at_end    = tick >= NEAR_END_TICK;         // Early edge for the next slot
    next_slot = slot + 1'b1;                   // Wraps 3 to 0 by width

    pos.final_tick      = tick == LAST_TICK;
    pos.final_slot      = slot == LAST_SLOT;
    pos.near_begin      = at_begin | at_end;
    pos.near_slot       = at_end ? next_slot : slot;
    pos.final_near_tick = tick == CHECK_TICK;
    pos.final_near_slot = pos.near_slot == LAST_SLOT;
  end

endmodule

// ==== logic/frame_sync_fsm.sv ====
`timescale 1ns/1ns

module frame_sync_fsm import oppm_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      pulse_edge, // Qualified rising edge
  input  slot_pos_t pos,        // Slot timer position
  output logic      tmr_start,
  output logic      tmr_clear,
  output buf_ctrl_t ctrl        // Packet buffer control
);

  fsm_state_t         state;
  fsm_state_t         state_next;
  logic [PRE_SZ-1:0]  pre_cnt;   // Preamble edges seen
  logic [DSYM_SZ-1:0] dsym_cnt;  // Data symbols taken
  logic               pre_up;
  logic               dsym_up;
  logic               cnt_clear;
  logic               seen;      // Pulse seen in this symbol
  logic               in_window;
  logic               miss_check;
  logic               abort;

  always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
      state <= WAIT;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
      pre_cnt <= '0;
    end else if (cnt_clear) begin
      pre_cnt <= '0;
    end else if (pre_up) begin
      pre_cnt <= pre_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
      dsym_cnt <= '0;
    end else if (cnt_clear) begin
      dsym_cnt <= '0;
    end else if (dsym_up) begin
      dsym_cnt <= dsym_cnt + 1'b1;
    end
  end

  // Set by every edge, dropped at each symbol's check tick
  always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
      seen <= 1'b0;
    end else if (pulse_edge) begin
      seen <= 1'b1;
    end else if (miss_check | (state == WAIT)) begin
      seen <= 1'b0;
    end
  end

  assign in_window  = pulse_edge & pos.near_begin;
  assign miss_check = pos.final_near_tick & pos.final_near_slot;

  always_comb begin
    state_next = state;
    tmr_start  = 1'b0;
    tmr_clear  = 1'b0;
    ctrl       = '0;
    pre_up     = 1'b0;
    dsym_up    = 1'b0;
    cnt_clear  = 1'b0;
    abort      = 1'b0;

    unique case (state)
      WAIT: begin
        if (pulse_edge) begin
          state_next    = PREAM;
          tmr_start     = 1'b1;
          pre_up        = 1'b1;       // This edge is preamble 1
          ctrl.reload   = 1'b1;
          ctrl.incoming = 1'b1;
        end else begin
          tmr_clear = 1'b1;
          cnt_clear = 1'b1;
        end
      end
      PREAM: begin
        if (in_window) begin
          if (pre_cnt == PRE_DONE) begin
            state_next = DATA;        // First data symbol
            ctrl.shift = 1'b1;
            ctrl.sym   = pos.near_slot;
            dsym_up    = 1'b1;
          end else if (pos.near_slot == '0) begin
            pre_up = 1'b1;
          end else begin
            abort = 1'b1;             // Preamble off slot 0
          end
        end else if (pulse_edge) begin
          abort = 1'b1;               // Outside every window
        end else if (miss_check & ~seen) begin
          abort = 1'b1;
        end
      end
      DATA: begin
        if (in_window) begin
          ctrl.shift = 1'b1;
          ctrl.sym   = pos.near_slot;
          if (dsym_cnt == LAST_DSYM) begin
            state_next = WAIT;
            ctrl.ready = 1'b1;
            tmr_clear  = 1'b1;
            cnt_clear  = 1'b1;
          end else begin
            dsym_up = 1'b1;
          end
        end else if (pulse_edge | (miss_check & ~seen)) begin
          abort = 1'b1;
        end
      end
      ERR: begin
        state_next  = WAIT;
        ctrl.fault  = 1'b1;
        ctrl.reload = 1'b1;
        tmr_clear   = 1'b1;
        cnt_clear   = 1'b1;
      end
    endcase

    if (abort) begin
      state_next = ERR;
      tmr_clear  = 1'b1;
      cnt_clear  = 1'b1;
    end
  end

endmodule

// ==== logic/packet_buffer.sv ====
`timescale 1ns/1ns

module packet_buffer import oppm_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  buf_ctrl_t ctrl,
  input  logic      read,  // Consumer took the result
  output pkt_t      data,
  output logic      avail,
  output logic      error
);

  pkt_t pkt;

  // MSB-first shift-in with the oldest symbol on top
  always_ff @(posedge clk) begin
    if (ctrl.reload) begin
      pkt <= '0;
    end else if (ctrl.shift) begin
      pkt <= {pkt[N_PKT-N_MOD-1:0], ctrl.sym};
    end
  end

  assign data = pkt;

  // Held until read or the next frame's first edge
  always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
      avail <= 1'b0;
    end else if (avail) begin
      avail <= ~(read | ctrl.incoming);
    end else begin
      avail <= ctrl.ready;
    end
  end

  // Same hold rule as avail
  always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
      error <= 1'b0;
    end else if (error) begin
      error <= ~(read | ctrl.incoming);
    end else begin
      error <= ctrl.fault;
    end
  end

endmodule

// ==== logic/oppm_receiver.sv ====
`timescale 1ns/1ns

module oppm_receiver import oppm_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic pulse, // Raw OPPM pulse line
  input  logic read,
  output pkt_t data,
  output logic avail,
  output logic error
);

  logic      pulse_edge;
  logic      tmr_start;
  logic      tmr_clear;
  slot_pos_t pos;
  buf_ctrl_t ctrl;

  pulse_qualifier i_pulse_qualifier (
    .clk        (clk),
    .rst_n      (rst_n),
    .pulse      (pulse),
    .pulse_edge (pulse_edge)
  );

  slot_timer i_slot_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .start (tmr_start),
    .clear (tmr_clear),
    .pos   (pos)
  );

  frame_sync_fsm i_frame_sync_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .pulse_edge (pulse_edge),
    .pos        (pos),
    .tmr_start  (tmr_start),
    .tmr_clear  (tmr_clear),
    .ctrl       (ctrl)
  );

  packet_buffer i_packet_buffer (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl),
    .read  (read),
    .data  (data),
    .avail (avail),
    .error (error)
  );

endmodule

// ==== tb/oppm_receiver_props.sv ====
`timescale 1ns/1ns

module oppm_receiver_props import oppm_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       pulse_edge,
  input buf_ctrl_t  ctrl,
  input fsm_state_t state
);

  edge_single: assert property (@(posedge clk) disable iff (~rst_n)
    pulse_edge |=> ~pulse_edge)
    else $error("pulse_edge stayed high for two cycles");

  fault_xor_ready: assert property (@(posedge clk) disable iff (~rst_n)
    ~(ctrl.fault & ctrl.ready))
    else $error("fault and ready high in the same cycle");

  // Error state lasts one cycle
  err_to_wait: assert property (@(posedge clk) disable iff (~rst_n)
    state == ERR |=> state == WAIT)
    else $error("FSM did not return to WAIT after ERR");

  delta_fits: assert property (@(posedge clk) DELTA < L / 2)
    else $error("DELTA must stay below half a slot");

endmodule

bind frame_sync_fsm oppm_receiver_props i_oppm_receiver_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .pulse_edge (pulse_edge),
  .ctrl       (ctrl),
  .state      (state)
);

// ==== tb/tb_oppm_receiver.sv ====
`timescale 1ns/1ns

module tb_oppm_receiver import oppm_pkg::*; ();

  localparam int FRAME_SYM   = PRE_CT + DATA_SYM_CT;
  localparam int PULSE_W     = FILTER_LEN + 3; // Raw pulse width in cycles
  localparam int N_FRAMES    = 14;
  localparam int WATCHDOG_NS = N_FRAMES * (FRAME_SYM + 2) * SYM_LEN * 4 * 2;

  logic clk;
  logic rst_n;
  logic pulse;
  logic read;
  pkt_t data;
  logic avail;
  logic error;

  int slot_of [FRAME_SYM]; // Nominal slot of each frame symbol
  int off_of  [FRAME_SYM]; // Tick offset from that slot's start
  bit drop    [FRAME_SYM]; // Pulse left out of the frame

  oppm_receiver i_oppm_receiver (
    .clk   (clk),
    .rst_n (rst_n),
    .pulse (pulse),
    .read  (read),
    .data  (data),
    .avail (avail),
    .error (error)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    abort_run();
  end

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("FAIL %s got %h expected %h at %0t", name, got, want, $time);
      abort_run();
    end
  endtask

  task automatic check_pkt(input pkt_t got, input pkt_t want);
    if (got !== want) begin
      $display("FAIL data got %h expected %h at %0t", got, want, $time);
      abort_run();
    end
  endtask

  // Slots from the packet, MSB-first; preamble in slot 0, no offsets
  task automatic load_frame(input pkt_t pkt);
    for (int i = 0; i < FRAME_SYM; i++) begin
      slot_of[i] = 0;
      off_of[i]  = 0;
      drop[i]    = 1'b0;
    end
    for (int j = 0; j < DATA_SYM_CT; j++) begin
      slot_of[PRE_CT + j] = int'(pkt[N_PKT-1 - j*N_MOD -: N_MOD]);
    end
  endtask

  // Ticks up to DELTA keep their slot and later ones move to the next slot
  function automatic pkt_t expected_pkt();
    int   pos;
    int   tick;
    int   slot;
    pkt_t want;
    want = '0;
    for (int i = PRE_CT; i < FRAME_SYM; i++) begin
      pos  = i * SYM_LEN + slot_of[i] * L + off_of[i];
      tick = pos % L;
      slot = (pos / L) % SLOT_CT;
      if (tick > DELTA) slot = (slot + 1) % SLOT_CT; // Early edge
      want[N_PKT-1 - (i-PRE_CT)*N_MOD -: N_MOD] = sym_t'(slot);
    end
    return want;
  endfunction

  // Drives the first n_sym pulses of the loaded frame
  task automatic send_frame(input int n_sym);
    int   pos [FRAME_SYM];
    int   last;
    logic level;
    last = 0;
    for (int i = 0; i < n_sym; i++) begin
      pos[i] = i * SYM_LEN + slot_of[i] * L + off_of[i];
      if (!drop[i] && pos[i] > last) last = pos[i];
    end
    for (int c = 0; c <= last + PULSE_W; c++) begin
      level = 1'b0;
      for (int i = 0; i < n_sym; i++) begin
        if (!drop[i] && c >= pos[i] && c < pos[i] + PULSE_W) level = 1'b1;
      end
      @(posedge clk);
      pulse <= level;
    end
  endtask

  // Waits for avail or error; the other flag must stay low meanwhile
  task automatic wait_result(input bit want_error, input int limit);
    bit hit;
    hit = 1'b0;
    for (int n = 0; n < limit && !hit; n++) begin
      @(negedge clk);
      hit = want_error ? error : avail;
      if (!hit) check_flag(want_error ? "avail" : "error", want_error ? avail : error, 1'b0);
    end
    if (!hit) begin
      $display("Timed out after %0d cycles waiting for %s", limit,
               want_error ? "error" : "avail");
      abort_run();
    end
  endtask

  task automatic read_result();
    @(posedge clk);
    read <= 1'b1;
    @(posedge clk);
    read <= 1'b0;
    @(negedge clk);
    check_flag("avail", avail, 1'b0);
    check_flag("error", error, 1'b0);
  endtask

  // Sends the loaded frame and expects its packet, held until read
  task automatic send_and_check();
    pkt_t want;
    want = expected_pkt();
    fork
      send_frame(FRAME_SYM);
      begin
        repeat (PULSE_W) @(negedge clk);
        check_flag("error", error, 1'b0); // Cleared by the first edge
      end
    join
    wait_result(1'b0, SYM_LEN);
    repeat (8) begin
      @(negedge clk);
      check_flag("avail", avail, 1'b1);
      check_pkt(data, want);
    end
    read_result();
  endtask

  task automatic test_good_frames();
    for (int k = 0; k < 4; k++) begin
      load_frame(pkt_t'($urandom));
      send_and_check();
    end
  endtask

  task automatic test_window_edges();
    load_frame(8'h8D);          // Slots 2, 0, 3, 1
    off_of[PRE_CT]     = DELTA;
    off_of[PRE_CT + 1] = -DELTA; // Late in slot 3 of the symbol before wraps to 0
    off_of[PRE_CT + 2] = -DELTA; // Late in slot 2 counts as 3
    off_of[PRE_CT + 3] = DELTA;
    send_and_check();
    load_frame(pkt_t'($urandom));
    for (int j = PRE_CT; j < FRAME_SYM; j++) begin
      off_of[j] = int'($urandom_range(2)) * DELTA - DELTA;
    end
    send_and_check();
  endtask

  task automatic test_wrong_preamble();
    load_frame(pkt_t'($urandom));
    slot_of[1] = 2;
    send_frame(PRE_CT);
    wait_result(1'b1, SYM_LEN);
    repeat (4) begin
      @(negedge clk);
      check_flag("error", error, 1'b1);
      check_flag("avail", avail, 1'b0);
    end
    read_result();
    load_frame(pkt_t'($urandom));
    send_and_check();
  endtask

  task automatic test_out_of_window();
    load_frame(pkt_t'($urandom));
    off_of[PRE_CT + 1] = L / 2;
    send_frame(PRE_CT + 2);
    wait_result(1'b1, SYM_LEN);
    load_frame(pkt_t'($urandom)); // Error stays unread until the next frame
    send_and_check();
  endtask

  task automatic test_missing_symbol();
    load_frame(pkt_t'($urandom));
    drop[PRE_CT + 1] = 1'b1;
    send_frame(PRE_CT + 2);
    wait_result(1'b1, 2 * SYM_LEN);
    read_result();
  endtask

  task automatic test_glitches();
    for (int g = 0; g < 6; g++) begin
      repeat (FILTER_LEN) begin
        @(posedge clk);
        pulse <= 1'b1;
      end
      repeat (7) begin
        @(posedge clk);
        pulse <= 1'b0;
      end
    end
    repeat (2 * SYM_LEN) begin
      @(negedge clk);
      check_flag("avail", avail, 1'b0);
      check_flag("error", error, 1'b0);
    end
    load_frame(pkt_t'($urandom));
    send_and_check();
  endtask

  initial begin
    void'($urandom(21));
    rst_n = 1'b0;
    pulse = 1'b0;
    read  = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    test_good_frames();
    test_window_edges();
    test_wrong_preamble();
    test_out_of_window();
    test_missing_symbol();
    test_glitches();
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== compile.f ====
logic/oppm_pkg.sv
logic/pulse_qualifier.sv
logic/slot_timer.sv
logic/frame_sync_fsm.sv
logic/packet_buffer.sv
logic/oppm_receiver.sv
tb/oppm_receiver_props.sv
tb/tb_oppm_receiver.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the OPPM receiver testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -f compile.f --top-module tb_oppm_receiver -o tb_oppm_receiver
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_oppm_receiver > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
  echo "Simulation failed"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation passed"
exit 0
